// File: sources.f
design/snd_pkg.sv
design/snd_stream_if.sv
design/snd_wb_regs.sv
design/snd_sigma_delta.sv
design/snd_dac_top.sv
tb/snd_dac_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the sound DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module snd_dac_tb -Mdir obj_dir -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vsnd_dac_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: tb/snd_dac_tb.sv
module snd_dac_tb import snd_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT = 16;
    localparam int SETTLE_CYC  = 8;
    localparam int EN_COUNT    = 4096;

    logic             clk_dac = 1'b0;
    logic             rst;
    logic             wb_cyc_i;
    logic             wb_stb_i;
    logic             wb_we_i;
    logic [WB_AW-1:0] wb_adr_i;
    logic [WB_DW-1:0] wb_dat_i;
    logic [WB_DW-1:0] wb_dat_o;
    logic             wb_ack_o;
    logic             snd_left_o;
    logic             snd_right_o;

    int seed = 28878;

    // pin counters owned by the counting process
    logic [1:0] phase = '0;
    logic       meas_on = 1'b0;
    int         meas_len = 0;
    int         smp_cnt = 0;
    int         ones_l = 0;
    int         ones_r = 0;
    int         mism = 0;

    snd_dac_top snd_dac_top_inst (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .wb_cyc_i    ( wb_cyc_i    ),
        .wb_stb_i    ( wb_stb_i    ),
        .wb_we_i     ( wb_we_i     ),
        .wb_adr_i    ( wb_adr_i    ),
        .wb_dat_i    ( wb_dat_i    ),
        .wb_dat_o    ( wb_dat_o    ),
        .wb_ack_o    ( wb_ack_o    ),
        .snd_left_o  ( snd_left_o  ),
        .snd_right_o ( snd_right_o )
    );

    always #50 clk_dac = ~clk_dac;

    // one pin sample per enable period with the phase counted from reset
    always @(negedge clk_dac) begin
        if (rst) begin
            phase = '0;
        end else begin
            phase = phase + 2'd1;
        end
        if (!meas_on) begin
            ones_l  = 0;
            ones_r  = 0;
            mism    = 0;
            smp_cnt = 0;
        end else if (phase == 2'd0 && smp_cnt < meas_len) begin
            if (snd_left_o) ones_l++;
            if (snd_right_o) ones_r++;
            if (snd_left_o !== snd_right_o) mism++;
            smp_cnt++;
        end
    end

    // carries of a first order modulator over k enables from a zero start
    function automatic int expected_ones(input logic [SND_W-1:0] smp, input logic sgn,
                                         input int k);
        logic [SND_W-1:0] fmt;
        longint unsigned  padded;
        longint unsigned  total;
        fmt = smp;
        if (sgn) fmt[SND_W-1] = ~fmt[SND_W-1];
        // one zero bit on top and three below
        padded = longint'(fmt) * 8;
        total  = padded * longint'(k);
        return int'(total >> MOD_W);
    endfunction

    task automatic stop_on_error();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input snd_word_u got, input snd_word_u exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    // accepts exp up to exp + slack
    task automatic check_count(input string name, input int got, input int exp, input int slack);
        if (got < exp || got > exp + slack) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h to 0x%0h",
                     name, got, exp, exp + slack);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic settle();
        repeat (SETTLE_CYC) @(negedge clk_dac);
    endtask

    task automatic write_reg(input logic [WB_AW-1:0] adr, input snd_word_u dat);
        int waited;
        @(negedge clk_dac);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        waited = 0;
        do begin
            @(negedge clk_dac);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("no ack within %0d cycles on a write to address %0d", ACK_TIMEOUT, adr);
                stop_on_error();
            end
        end while (!wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic read_reg(input logic [WB_AW-1:0] adr, output snd_word_u dat);
        int waited;
        @(negedge clk_dac);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        waited = 0;
        do begin
            @(negedge clk_dac);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("no ack within %0d cycles on a read from address %0d", ACK_TIMEOUT, adr);
                stop_on_error();
            end
        end while (!wb_ack_o);
        dat      = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    // count pin ones over k enables
    task automatic measure(input int k, output int nl, output int nr, output int nm);
        int waited;
        @(posedge clk_dac);
        meas_len = k;
        meas_on  = 1'b1;
        waited   = 0;
        while (smp_cnt < k) begin
            @(posedge clk_dac);
            waited++;
            if (waited > k * CEN_DIV + 64) begin
                $display("pin sampling did not reach %0d enables in time", k);
                stop_on_error();
            end
        end
        nl      = ones_l;
        nr      = ones_r;
        nm      = mism;
        meas_on = 1'b0;
    endtask

    task automatic density_case(input snd_sample_t s, input logic sgn);
        snd_word_u w;
        int        nl;
        int        nr;
        int        nm;
        w.sample = s;
        write_reg(ADDR_SAMPLE, w);
        settle();
        measure(EN_COUNT, nl, nr, nm);
        check_count("snd_left_o ones", nl, expected_ones(s.left, sgn, EN_COUNT), 1);
        check_count("snd_right_o ones", nr, expected_ones(s.right, sgn, EN_COUNT), 1);
    endtask

    initial begin
        snd_word_u   wr;
        snd_word_u   rd;
        snd_word_u   exp;
        snd_sample_t smp;
        logic [WB_DW-1:0] rnd;
        int nl;
        int nr;
        int nm;

        rst      = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (16) @(negedge clk_dac);
        rst = 1'b0;

        // reset state
        @(negedge clk_dac);
        check_bit("wb_ack_o", wb_ack_o, 1'b0);
        check_bit("snd_left_o", snd_left_o, 1'b0);
        check_bit("snd_right_o", snd_right_o, 1'b0);
        measure(16, nl, nr, nm);
        check_count("snd_left_o ones after reset", nl, 0, 0);
        check_count("snd_right_o ones after reset", nr, 0, 0);
        read_reg(ADDR_CTRL, rd);
        check_word("wb_dat_o ctrl after reset", rd, '0);
        read_reg(ADDR_SAMPLE, rd);
        check_word("wb_dat_o sample after reset", rd, '0);

        // readback with the reserved control bits reading as zero
        wr = 32'hFFFF_FFFF;
        write_reg(ADDR_CTRL, wr);
        read_reg(ADDR_CTRL, rd);
        check_word("wb_dat_o ctrl readback", rd, 32'h0000_0007);
        repeat (3) begin
            rnd = $random(seed);
            wr  = rnd;
            write_reg(ADDR_CTRL, wr);
            read_reg(ADDR_CTRL, rd);
            exp = rnd & 32'h0000_0007;
            check_word("wb_dat_o ctrl readback", rd, exp);
            rnd = $random(seed);
            wr  = rnd;
            write_reg(ADDR_SAMPLE, wr);
            read_reg(ADDR_SAMPLE, rd);
            check_word("wb_dat_o sample readback", rd, wr);
        end

        // unsigned stereo
        wr = 32'h0000_0001;
        write_reg(ADDR_CTRL, wr);
        repeat (3) begin
            rnd = $random(seed);
            smp = rnd;
            density_case(smp, 1'b0);
        end

        // signed stereo where 0x8000 maps to zero density
        wr = 32'h0000_0003;
        write_reg(ADDR_CTRL, wr);
        rnd = $random(seed);
        smp = {16'h8000, rnd[15:0]};
        density_case(smp, 1'b1);
        rnd = $random(seed);
        smp = rnd;
        density_case(smp, 1'b1);

        // mono mode mirrors the left pin even with a different right sample
        wr = 32'h0000_0000;
        write_reg(ADDR_CTRL, wr);
        rnd = $random(seed);
        smp.left  = rnd[31:16];
        smp.right = rnd[31:16] ^ 16'h5A5A;
        wr.sample = smp;
        write_reg(ADDR_SAMPLE, wr);
        settle();
        measure(EN_COUNT, nl, nr, nm);
        check_count("snd_right_o mismatches with snd_left_o", nm, 0, 0);
        check_count("snd_left_o ones", nl, expected_ones(smp.left, 1'b0, EN_COUNT), 1);

        // mute holds both pins low
        wr = 32'h0000_0005;
        write_reg(ADDR_CTRL, wr);
        rnd = $random(seed);
        wr  = rnd | 32'h4000_4000;
        write_reg(ADDR_SAMPLE, wr);
        settle();
        measure(EN_COUNT, nl, nr, nm);
        check_count("snd_left_o ones muted", nl, 0, 0);
        check_count("snd_right_o ones muted", nr, 0, 0);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: design/snd_dac_top.sv
module snd_dac_top import snd_pkg::*; (
    input  logic             clk_dac,
    input  logic             rst,
    // wishbone slave
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [WB_AW-1:0] wb_adr_i,
    input  logic [WB_DW-1:0] wb_dat_i,
    output logic [WB_DW-1:0] wb_dat_o,
    output logic             wb_ack_o,
    // sigma-delta pins
    output logic             snd_left_o,
    output logic             snd_right_o
);

    logic [CEN_DIV-1:0] cen_sr;

    snd_stream_if strm ();

    // ring of one hot bit, cen on the low bit
    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            cen_sr <= CEN_DIV'(3'b100);
        end else begin
            cen_sr <= {cen_sr[CEN_DIV-2:0], cen_sr[CEN_DIV-1]};
        end
    end

    assign strm.cen = cen_sr[0];

    snd_wb_regs u_regs (
        .clk_dac  ( clk_dac  ),
        .rst      ( rst      ),
        .wb_cyc_i ( wb_cyc_i ),
        .wb_stb_i ( wb_stb_i ),
        .wb_we_i  ( wb_we_i  ),
        .wb_adr_i ( wb_adr_i ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack_o ( wb_ack_o ),
        .strm     ( strm.src )
    );

    snd_sigma_delta #(
        .RIGHT    ( 0          )
    ) u_left (
        .clk_dac  ( clk_dac    ),
        .rst      ( rst        ),
        .strm     ( strm.sink  ),
        .pcm_o    ( snd_left_o )
    );

    // mono selection and mute are handled inside the channel
    snd_sigma_delta #(
        .RIGHT    ( 1           )
    ) u_right (
        .clk_dac  ( clk_dac     ),
        .rst      ( rst         ),
        .strm     ( strm.sink   ),
        .pcm_o    ( snd_right_o )
    );

endmodule

// File: design/snd_sigma_delta.sv
module snd_sigma_delta import snd_pkg::*; #(
    parameter int RIGHT = 0
) (
    input  logic       clk_dac,
    input  logic       rst,
    snd_stream_if.sink strm,
    output logic       pcm_o
);

    logic [SND_W-1:0] snd_sel;
    logic [SND_W-1:0] snd_fmt;
    logic [MOD_W-1:0] snd_padded;
    logic [MOD_W-1:0] acc;
    logic [MOD_W-1:0] acc_base;
    logic [MOD_W:0]   sum;
    logic             stereo_q;
    logic             realign;
    logic             pcm_q;

    // right channel follows the left sample in mono mode
    assign snd_sel = (RIGHT != 0 && strm.stereo) ? strm.right : strm.left;

    // offset binary for the modulator
    assign snd_fmt = {snd_sel[SND_W-1] ^ strm.signed_snd, snd_sel[SND_W-2:0]};

    // one zero on top keeps the carry density below one
    assign snd_padded = {1'b0, snd_fmt, {PAD_W{1'b0}}};

    // Entering mono restarts both accumulators together, so from then on
    // the two channels see the same word from the same state and the
    // right pin mirrors the left one.
    assign realign  = stereo_q & ~strm.stereo;
    assign acc_base = realign ? '0 : acc;
    assign sum      = {1'b0, acc_base} + {1'b0, snd_padded};

    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            acc      <= '0;
            pcm_q    <= 1'b0;
            stereo_q <= 1'b0;
        end else if (strm.cen) begin
            stereo_q <= strm.stereo;
            if (strm.mute) begin
                // muted: pin low, accumulator frozen
                acc   <= acc_base;
                pcm_q <= 1'b0;
            end else begin
                acc   <= sum[MOD_W-1:0];
                pcm_q <= sum[MOD_W];
            end
        end
    end

    assign pcm_o = pcm_q;

endmodule

// File: design/snd_wb_regs.sv
module snd_wb_regs import snd_pkg::*; (
    input  logic             clk_dac,
    input  logic             rst,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [WB_AW-1:0] wb_adr_i,
    input  logic [WB_DW-1:0] wb_dat_i,
    output logic [WB_DW-1:0] wb_dat_o,
    output logic             wb_ack_o,
    snd_stream_if.src        strm
);

    logic        wb_req;
    logic        ack_q;
    snd_word_u   wr_word;
    snd_word_u   rd_word;
    snd_word_u   dat_q;
    snd_ctrl_t   ctrl_q;
    snd_sample_t sample_q;

    // new access with no ack given yet
    assign wb_req  = wb_cyc_i & wb_stb_i & ~ack_q;
    assign wr_word = wb_dat_i;

    // single cycle ack that drops again on the following cycle
    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req;
        end
    end

    // register writes land on the ack edge
    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            ctrl_q   <= '0;
            sample_q <= '0;
        end else if (wb_req && wb_we_i) begin
            case (wb_adr_i)
                ADDR_CTRL: begin
                    // reserved bits are not stored
                    ctrl_q.stereo     <= wr_word.ctrl.stereo;
                    ctrl_q.signed_snd <= wr_word.ctrl.signed_snd;
                    ctrl_q.mute       <= wr_word.ctrl.mute;
                end
                ADDR_SAMPLE: begin
                    sample_q <= wr_word.sample;
                end
                default: begin
                    sample_q <= sample_q;
                end
            endcase
        end
    end

    // read mux through the union views
    always_comb begin
        rd_word = '0;
        case (wb_adr_i)
            ADDR_CTRL: begin
                rd_word.ctrl.stereo     = ctrl_q.stereo;
                rd_word.ctrl.signed_snd = ctrl_q.signed_snd;
                rd_word.ctrl.mute       = ctrl_q.mute;
            end
            ADDR_SAMPLE: begin
                rd_word.sample = sample_q;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // read data presented with ack
    always_ff @(posedge clk_dac, posedge rst) begin
        if (rst) begin
            dat_q <= '0;
        end else if (wb_req && !wb_we_i) begin
            dat_q <= rd_word;
        end
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;

    // held values towards the modulators
    assign strm.left       = sample_q.left;
    assign strm.right      = sample_q.right;
    assign strm.stereo     = ctrl_q.stereo;
    assign strm.signed_snd = ctrl_q.signed_snd;
    assign strm.mute       = ctrl_q.mute;

endmodule

// File: design/snd_stream_if.sv
interface snd_stream_if import snd_pkg::*; ();

    // held samples
    logic [SND_W-1:0] left;
    logic [SND_W-1:0] right;

    // mode bits
    logic             stereo;
    logic             signed_snd;
    logic             mute;

    // modulator clock enable
    logic             cen;

    modport src (
        output left, right, stereo, signed_snd, mute
    );

    modport gen (
        output cen
    );

    modport sink (
        input left, right, stereo, signed_snd, mute, cen
    );

endinterface

// File: design/snd_pkg.sv
package snd_pkg;

    // sample and modulator widths
    localparam int SND_W = 16;
    localparam int MOD_W = 20;

    // zero bits below the sample in the modulator word
    localparam int PAD_W = MOD_W - SND_W - 1;

    // wishbone word and address widths
    localparam int WB_DW = 32;
    localparam int WB_AW = 1;

    localparam logic [WB_AW-1:0] ADDR_CTRL   = 1'b0;
    localparam logic [WB_AW-1:0] ADDR_SAMPLE = 1'b1;

    // cen is high one clk_dac cycle in CEN_DIV
    localparam int CEN_DIV = 4;

    // control view of a bus word
    typedef struct packed {
        logic [WB_DW-4:0] rsv;
        logic             mute;
        logic             signed_snd;
        logic             stereo;
    } snd_ctrl_t;

    // sample view of a bus word, left channel in the upper half
    typedef struct packed {
        logic [SND_W-1:0] left;
        logic [SND_W-1:0] right;
    } snd_sample_t;

    // one bus word, decoded by address
    typedef union packed {
        snd_ctrl_t   ctrl;
        snd_sample_t sample;
    } snd_word_u;

endpackage
